/* filelist.f */
+incdir+include
src/synth_pkg.sv
src/midi_voice_ctrl.sv
src/pitch_table.sv
src/wave_oscillator.sv
src/pwm_dac.sv
src/synth_voice_top.sv
sim/synth_voice_asserts.sv
sim/synth_voice_tb.sv

/* include/synth_params.svh */
`ifndef SYNTH_PARAMS_SVH
`define SYNTH_PARAMS_SVH

// phase accumulator width, sets pitch resolution
`define SYN_PHASE_W 24

// signed audio sample width
`define SYN_SAMPLE_W 16

// dac resolution, also the pwm period in bits
`define SYN_PWM_W 12

// playable note range, A0 up to B8
`define SYN_NOTE_LO 21
`define SYN_NOTE_HI 119

// octave held in the semitone table (notes 108..119)
`define SYN_TOP_OCTAVE 9
`define SYN_SEMITONES 12

// quarter-wave sine table depth
`define SYN_SINE_DEPTH 64

// pitch bend byte meaning no bend
`define SYN_BEND_CENTER 64

`endif

/* sim/synth_testdata.mem */
// cmd: 1 midi message, 2 ticks, 3 pwm window, 0 end
// columns: cmd  midi word or count  wave_sel  note_active  sample (duty for pwm)
2 00000003 0 0 0000
1 00904540 0 1 0000
2 00000003 0 1 7FFF
2 00000005 1 1 92C5
2 0000003C 0 1 8000
1 00906C64 1 1 0000
2 00000003 1 1 C2F9
2 00000009 1 1 8BE7
1 00903950 2 1 0000
2 0000000A 2 1 23A6
2 00000028 2 1 7ED5
2 00000046 3 1 6666
2 0000003C 2 1 8E63
1 00E00070 1 1 0000
2 0000000A 1 1 5F7B
1 00E00010 1 1 0000
2 0000000A 1 1 6AAA
1 00907840 1 1 0000
1 00901440 1 1 0000
1 00A04540 1 1 0000
2 0000000A 1 1 75D9
1 00904540 1 1 0000
2 00000014 1 1 ACBB
1 00803900 1 1 0000
2 00000005 1 1 B7EA
1 00804500 1 0 0000
2 00000003 1 0 0000
1 00906C64 1 1 0000
1 00906C00 1 0 0000
2 00000002 1 0 0000
1 00903950 3 1 0000
2 0000001E 3 1 C318
3 00001000 3 1 0431
0 00000000 0 0 0000

/* sim/synth_voice_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

`include "synth_params.svh"

module synth_voice_asserts (
	input wire logic                            clock,
	input wire logic                            reset,
	input wire logic                            sample_tick,
	input wire logic signed [`SYN_SAMPLE_W-1:0] sample,
	input wire logic                            sample_valid,
	input wire logic                            note_active,
	input wire logic                            pwm_out
);

	// failed assertion count, watched from the testbench
	int fail_count;

	// valid pulse comes two edges after the tick was sampled
	property valid_follows_tick;
		@(posedge clock) disable iff (reset)
			sample_valid |-> $past(sample_tick, 2);
	endproperty

	// ticks are spaced, so valid never stretches
	property valid_single_cycle;
		@(posedge clock) disable iff (reset)
			sample_valid |=> !sample_valid;
	endproperty

	// silence while the gate is low, no stale sample when it comes back
	property silent_when_off;
		@(posedge clock) disable iff (reset)
			!note_active |=> (sample == '0);
	endproperty

	// outputs parked once reset has been seen for an edge
	property quiet_in_reset;
		@(posedge clock)
			(reset && $past(reset)) |-> (!pwm_out && !sample_valid);
	endproperty

	a_valid_follows_tick: assert property (valid_follows_tick)
		else begin
			fail_count++;
			$error("sample_valid without a sample_tick two cycles earlier");
		end
	a_valid_single_cycle: assert property (valid_single_cycle)
		else begin
			fail_count++;
			$error("sample_valid held longer than one cycle");
		end
	a_silent_when_off: assert property (silent_when_off)
		else begin
			fail_count++;
			$error("sample not zero after note_active was low");
		end
	a_quiet_in_reset: assert property (quiet_in_reset)
		else begin
			fail_count++;
			$error("pwm_out or sample_valid high during reset");
		end

endmodule

bind synth_voice_top synth_voice_asserts i_synth_voice_asserts (
	.clock        (clock),
	.reset        (reset),
	.sample_tick  (sample_tick),
	.sample       (sample),
	.sample_valid (sample_valid),
	.note_active  (note_active),
	.pwm_out      (pwm_out)
);

`default_nettype wire

/* sim/synth_voice_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "synth_params.svh"

module synth_voice_tb import synth_pkg::*; ();

	// record commands in the data file
	localparam int CMD_END = 0;
	localparam int CMD_MSG = 1;
	localparam int CMD_TICK = 2;
	localparam int CMD_PWM = 3;
	localparam int VALID_TIMEOUT = 20;

	logic                            clock;
	logic                            reset;
	midi_word_t                      midi_word;
	logic                            midi_valid;
	wave_sel_e                       wave_sel;
	logic                            sample_tick;
	logic signed [`SYN_SAMPLE_W-1:0] sample;
	logic                            sample_valid;
	logic                            note_active;
	logic                            pwm_out;

	// five words per record: cmd, data, wave, active, expected
	logic [31:0] records [0:255];
	integer      seed;

	// reference voice state
	logic [7:0]  m_note;
	logic        m_on;
	logic [7:0]  m_bend;
	logic [23:0] m_base;
	logic [23:0] m_inc;
	logic [23:0] m_phase;
	logic [2:0]  m_wave;

	synth_voice_top i_synth_voice_top (
		.clock        (clock),
		.reset        (reset),
		.midi_word    (midi_word),
		.midi_valid   (midi_valid),
		.wave_sel     (wave_sel),
		.sample_tick  (sample_tick),
		.sample       (sample),
		.sample_valid (sample_valid),
		.note_active  (note_active),
		.pwm_out      (pwm_out)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			report_failure("value mismatch");
		end
	endtask

	// top octave increments, f * 2^24 / 48 kHz
	function automatic logic [23:0] top_octave_inc(input int semi);
		case (semi)
			0: return 24'd1463116;
			1: return 24'd1550118;
			2: return 24'd1642292;
			3: return 24'd1739948;
			4: return 24'd1843411;
			5: return 24'd1953026;
			6: return 24'd2069159;
			7: return 24'd2192197;
			8: return 24'd2322552;
			9: return 24'd2460658;
			10: return 24'd2606977;
			default: return 24'd2761996;
		endcase
	endfunction

	function automatic logic [23:0] bent_inc(input logic [23:0] base, input logic [7:0] b);
		int delta;
		delta = (int'(b) - 64) * int'(base / 16) / 64;
		return base + delta[23:0];
	endfunction

	function automatic logic [15:0] quarter_sine(input int idx);
		real ang;
		ang = (2.0 * idx + 1.0) * 3.14159265358979 / 256.0;
		return 16'($rtoi($sin(ang) * 32767.0 + 0.5));
	endfunction

	function automatic logic [15:0] shape(input logic [23:0] p, input logic [2:0] w);
		logic [14:0] fold;
		logic [15:0] mag;
		int          idx;
		case (w)
			3'd0: return p[23] ? 16'h8000 : 16'h7fff;
			3'd1: return {~p[23], p[22:8]};
			3'd2: begin
				idx = p[22] ? 63 - int'(p[21:16]) : int'(p[21:16]);
				mag = quarter_sine(idx);
				return p[23] ? -mag : mag;
			end
			default: begin
				fold = p[23] ? 15'h7fff - p[22:8] : p[22:8];
				return {fold, 1'b0} - 16'h8000;
			end
		endcase
	endfunction

	// reference decode of one message
	task automatic model_message(input logic [31:0] w);
		logic [3:0] st;
		logic [7:0] n;
		logic [7:0] vel;
		logic       ok;
		st = w[23:20];
		n = w[15:8];
		vel = w[7:0];
		ok = (n >= `SYN_NOTE_LO) && (n <= `SYN_NOTE_HI);
		if (st == 4'h9 && vel != 0 && ok) begin
			m_note = n;
			m_on = 1'b1;
			m_phase = '0;
			m_base = top_octave_inc(n % 12) >> (9 - n / 12);
			m_inc = bent_inc(m_base, m_bend);
		end else if ((st == 4'h8 || st == 4'h9) && ok && n == m_note) begin
			m_on = 1'b0;
			m_phase = '0;
		end else if (st == 4'hE) begin
			m_bend = w[7:0];
			m_inc = bent_inc(m_base, m_bend);
		end
	endtask

	task automatic send_message(input logic [31:0] w, input logic [2:0] wv,
			input logic [31:0] act);
		@(posedge clock);
		midi_word <= w;
		midi_valid <= 1'b1;
		wave_sel <= wave_sel_e'(wv[1:0]);
		@(posedge clock);
		midi_valid <= 1'b0;
		model_message(w);
		m_wave = wv;
		repeat (4) @(posedge clock);
		@(negedge clock);
		check_value("expected note_active", act, 32'(m_on));
		check_value("note_active", 32'(note_active), 32'(m_on));
	endtask

	task automatic run_ticks(input int count, input logic [2:0] wv, input logic [31:0] act,
			input logic [31:0] exp);
		int          gap;
		int          waited;
		logic [15:0] want;
		want = '0;
		@(posedge clock);
		wave_sel <= wave_sel_e'(wv[1:0]);
		m_wave = wv;
		for (int t = 0; t < count; t++) begin
			gap = 4 + ({$random(seed)} % 7);
			repeat (gap) @(posedge clock);
			sample_tick <= 1'b1;
			@(posedge clock);
			sample_tick <= 1'b0;
			if (m_on) begin
				m_phase = m_phase + m_inc;
			end
			waited = 0;
			do begin
				@(negedge clock);
				waited++;
			end while (!sample_valid && waited < VALID_TIMEOUT);
			if (!sample_valid) begin
				report_failure("timed out waiting for sample_valid after a tick");
			end
			want = m_on ? shape(m_phase, m_wave) : 16'h0000;
			check_value("sample", 32'($unsigned(sample)), 32'(want));
		end
		check_value("expected sample", exp, 32'(want));
		check_value("note_active", 32'(note_active), act);
	endtask

	// counts pwm high cycles over one window of a settled duty
	task automatic measure_pwm(input int window, input logic [31:0] exp);
		int          high;
		logic [11:0] duty;
		duty = shape(m_phase, m_wave) >> 4;
		duty = duty ^ 12'h800;
		check_value("expected duty", exp, 32'(duty));
		repeat (4200) @(posedge clock);
		high = 0;
		repeat (window) begin
			@(negedge clock);
			if (pwm_out) begin
				high++;
			end
		end
		// one period boundary of slack
		if (high >= int'(duty) - 1 && high <= int'(duty) + 1) begin
			high = int'(duty);
		end
		check_value("pwm_out high count", 32'(high), 32'(duty));
	endtask

	initial begin
		int r;
		midi_word = '0;
		midi_valid = 1'b0;
		wave_sel = SQUARE;
		sample_tick = 1'b0;
		reset = 1'b1;
		seed = 32'h7ee8;
		m_note = '0;
		m_on = 1'b0;
		m_bend = 8'(`SYN_BEND_CENTER);
		m_base = '0;
		m_inc = '0;
		m_phase = '0;
		m_wave = '0;
		$readmemh("sim/synth_testdata.mem", records);
		if ($isunknown(records[0])) begin
			report_failure("the stimulus file could not be read");
		end
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		r = 0;
		while (records[r * 5] != CMD_END) begin
			case (records[r * 5])
				CMD_MSG: send_message(records[r * 5 + 1], records[r * 5 + 2][2:0],
					records[r * 5 + 3]);
				CMD_TICK: run_ticks(records[r * 5 + 1], records[r * 5 + 2][2:0],
					records[r * 5 + 3], records[r * 5 + 4]);
				CMD_PWM: measure_pwm(records[r * 5 + 1], records[r * 5 + 4]);
				default: report_failure("unknown command in the stimulus file");
			endcase
			r++;
		end
		if (i_synth_voice_top.i_synth_voice_asserts.fail_count != 0) begin
			report_failure("a bound assertion on the DUT failed");
		end else begin
			$display("test passed");
			$finish;
		end
	end

	// a failed bound assertion ends the run at once
	always @(negedge clock) begin
		if (i_synth_voice_top.i_synth_voice_asserts.fail_count != 0) begin
			report_failure("a bound assertion on the DUT failed");
		end
	end

	// whole-run guard
	initial begin
		#5000000;
		report_failure("simulation ran too long without finishing");
	end

endmodule

`default_nettype wire

/* src/midi_voice_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "synth_params.svh"

module midi_voice_ctrl import synth_pkg::*; (
	input  logic                    clock,
	input  logic                    reset,
	input  midi_word_t              midi_word,
	input  logic                    midi_valid,
	input  logic [`SYN_PHASE_W-1:0] base_inc,
	input  logic                    inc_ready,
	output logic [7:0]              note,
	output logic                    note_load,
	output logic                    voice_on,
	output logic [`SYN_PHASE_W-1:0] phase_inc,
	output logic                    phase_clear
);

	// decoded message fields
	logic [7:0] msg_note;
	logic       in_range;
	logic       is_on;
	logic       is_off;
	logic       is_bend;

	// matching note-off, one cycle behind the message
	logic       off_hit;

	// bend state and bent increment math
	logic [7:0]              bend_byte;
	logic [`SYN_PHASE_W-1:0] base_hold;
	logic [`SYN_PHASE_W-1:0] base_sel;
	logic signed [8:0]       bend_off;
	logic signed [31:0]      bend_prod;
	logic signed [31:0]      bend_delta;

	always_comb begin
		msg_note = midi_word.note_msg.note;
		in_range = (msg_note >= `SYN_NOTE_LO) && (msg_note <= `SYN_NOTE_HI);
		is_on = 1'b0;
		is_off = 1'b0;
		is_bend = 1'b0;
		if (midi_valid) begin
			case (midi_word.note_msg.status)
				NOTE_ON: begin
					// velocity 0 is the running-status form of note-off
					if (midi_word.note_msg.velocity != 8'd0) begin
						is_on = in_range;
					end else begin
						is_off = in_range;
					end
				end
				NOTE_OFF: begin
					is_off = in_range;
				end
				PITCH_BEND: begin
					is_bend = 1'b1;
				end
				default: begin
					// other statuses fall through untouched
					is_bend = 1'b0;
				end
			endcase
		end
	end

	// new base increment wins in the cycle it shows up
	assign base_sel = inc_ready ? base_inc : base_hold;

	// delta = (b - 64) * (base / 16) / 64, truncating toward zero
	always_comb begin
		bend_off = $signed({1'b0, bend_byte}) - $signed(9'(`SYN_BEND_CENTER));
		bend_prod = bend_off * $signed({8'd0, base_sel >> 4});
		bend_delta = bend_prod / 32'sd64;
	end

	// phase restart rides on the same pulse as the table lookup
	assign phase_clear = note_load;

	always_ff @(posedge clock) begin
		if (reset) begin
			note <= 8'd0;
			note_load <= 1'b0;
			off_hit <= 1'b0;
			voice_on <= 1'b0;
			bend_byte <= 8'(`SYN_BEND_CENTER);
			base_hold <= '0;
			phase_inc <= '0;
		end else begin
			note_load <= is_on;
			// only the sounding note may release the voice
			off_hit <= is_off && (msg_note == note);
			if (is_on) begin
				note <= msg_note;
			end
			// gate follows the decode pulses, so it moves at N+1
			if (note_load) begin
				voice_on <= 1'b1;
			end else if (off_hit) begin
				voice_on <= 1'b0;
			end
			if (is_bend) begin
				bend_byte <= midi_word.bend_msg.bend;
			end
			if (inc_ready) begin
				base_hold <= base_inc;
			end
			// recomputed every cycle, bend or note both land here
			phase_inc <= base_sel + bend_delta[`SYN_PHASE_W-1:0];
		end
	end

endmodule

`default_nettype wire

/* src/pitch_table.sv */
`timescale 1ns/1ns
`default_nettype none

`include "synth_params.svh"

module pitch_table (
	input  logic                    clock,
	input  logic                    reset,
	input  logic [7:0]              note,
	input  logic                    note_load,
	output logic [`SYN_PHASE_W-1:0] base_inc,
	output logic                    inc_ready
);

	logic [7:0]              rem;
	logic [3:0]              octave;
	logic [3:0]              shift;
	logic [`SYN_PHASE_W-1:0] top_inc;

	// note / 12 and note % 12 without a divider
	always_comb begin
		rem = note;
		octave = 4'd0;
		for (int i = 0; i < `SYN_TOP_OCTAVE; i++) begin
			if (rem >= 8'(`SYN_SEMITONES)) begin
				rem = rem - 8'(`SYN_SEMITONES);
				octave = octave + 4'd1;
			end
		end
		shift = 4'(`SYN_TOP_OCTAVE) - octave;
	end

	// octave 9 increments, f * 2^24 / 48 kHz
	always_comb begin
		case (rem[3:0])
			4'd0:    top_inc = 24'd1463116;
			4'd1:    top_inc = 24'd1550118;
			4'd2:    top_inc = 24'd1642292;
			4'd3:    top_inc = 24'd1739948;
			4'd4:    top_inc = 24'd1843411;
			4'd5:    top_inc = 24'd1953026;
			4'd6:    top_inc = 24'd2069159;
			4'd7:    top_inc = 24'd2192197;
			4'd8:    top_inc = 24'd2322552;
			4'd9:    top_inc = 24'd2460658;
			4'd10:   top_inc = 24'd2606977;
			4'd11:   top_inc = 24'd2761996;
			default: top_inc = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (note_load) begin
			base_inc <= top_inc >> shift;
		end
	end

	// ready pulse lines up with the registered entry
	always_ff @(posedge clock) begin
		if (reset) begin
			inc_ready <= 1'b0;
		end else begin
			inc_ready <= note_load;
		end
	end

endmodule

`default_nettype wire

/* src/pwm_dac.sv */
`timescale 1ns/1ns
`default_nettype none

`include "synth_params.svh"

module pwm_dac (
	input  logic                     clock,
	input  logic                     reset,
	input  logic [`SYN_SAMPLE_W-1:0] sample,
	input  logic                     sample_valid,
	output logic                     pwm_out
);

	localparam int S = `SYN_SAMPLE_W;
	localparam int W = `SYN_PWM_W;

	// newest sample, duty only picks it up at the wrap
	logic [S-1:0] held;
	logic [W-1:0] count;
	logic [W-1:0] duty;

	always_ff @(posedge clock) begin
		if (reset) begin
			held <= '0;
			count <= '0;
			duty <= '0;
		end else begin
			if (sample_valid) begin
				held <= sample;
			end
			// free running, one full period is 2^12 clocks
			count <= count + 1'b1;
			// signed to offset binary, keep the top bits
			if (&count) begin
				duty <= {~held[S-1], held[S-2:S-W]};
			end
		end
	end

	// high for duty clocks out of each period
	assign pwm_out = (count < duty);

endmodule

`default_nettype wire

/* src/synth_pkg.sv */
`default_nettype none

package synth_pkg;

	// midi status nibbles this voice reacts to
	typedef enum logic [3:0] {
		NOTE_OFF   = 4'h8,
		NOTE_ON    = 4'h9,
		PITCH_BEND = 4'hE
	} midi_status_e;

	// waveform picked by the level input
	typedef enum logic [1:0] {
		SQUARE   = 2'd0,
		SAW      = 2'd1,
		SINE     = 2'd2,
		TRIANGLE = 2'd3
	} wave_sel_e;

	// note on / note off layout
	typedef struct packed {
		logic [7:0] pad;
		logic [3:0] status;
		logic [3:0] channel;
		logic [7:0] note;
		logic [7:0] velocity;
	} note_msg_t;

	// pitch bend layout, only the coarse byte is used
	typedef struct packed {
		logic [7:0] pad;
		logic [3:0] status;
		logic [3:0] channel;
		logic [7:0] lsb;
		logic [7:0] bend;
	} bend_msg_t;

	// one message word, two ways to read it
	typedef union packed {
		note_msg_t note_msg;
		bend_msg_t bend_msg;
	} midi_word_t;

endpackage

`default_nettype wire

/* src/synth_voice_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "synth_params.svh"

module synth_voice_top import synth_pkg::*; (
	input  logic                            clock,
	input  logic                            reset,
	input  midi_word_t                      midi_word,
	input  logic                            midi_valid,
	input  wave_sel_e                       wave_sel,
	input  logic                            sample_tick,
	output logic signed [`SYN_SAMPLE_W-1:0] sample,
	output logic                            sample_valid,
	output logic                            note_active,
	output logic                            pwm_out
);

	// control to pitch lookup
	logic [7:0]              note;
	logic                    note_load;
	logic [`SYN_PHASE_W-1:0] base_inc;
	logic                    inc_ready;

	// control to oscillator
	logic [`SYN_PHASE_W-1:0] phase_inc;
	logic                    voice_on;
	logic                    phase_clear;

	midi_voice_ctrl i_midi_voice_ctrl (
		.clock       (clock),
		.reset       (reset),
		.midi_word   (midi_word),
		.midi_valid  (midi_valid),
		.base_inc    (base_inc),
		.inc_ready   (inc_ready),
		.note        (note),
		.note_load   (note_load),
		.voice_on    (voice_on),
		.phase_inc   (phase_inc),
		.phase_clear (phase_clear)
	);

	pitch_table i_pitch_table (
		.clock     (clock),
		.reset     (reset),
		.note      (note),
		.note_load (note_load),
		.base_inc  (base_inc),
		.inc_ready (inc_ready)
	);

	wave_oscillator i_wave_oscillator (
		.clock        (clock),
		.reset        (reset),
		.sample_tick  (sample_tick),
		.voice_on     (voice_on),
		.phase_clear  (phase_clear),
		.phase_inc    (phase_inc),
		.wave_sel     (wave_sel),
		.sample       (sample),
		.sample_valid (sample_valid)
	);

	// sample also feeds the on-board audio pwm
	pwm_dac i_pwm_dac (
		.clock        (clock),
		.reset        (reset),
		.sample       (sample),
		.sample_valid (sample_valid),
		.pwm_out      (pwm_out)
	);

	// gate level seen from outside
	assign note_active = voice_on;

endmodule

`default_nettype wire

/* src/wave_oscillator.sv */
`timescale 1ns/1ns
`default_nettype none

`include "synth_params.svh"

module wave_oscillator import synth_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     sample_tick,
	input  logic                     voice_on,
	input  logic                     phase_clear,
	input  logic [`SYN_PHASE_W-1:0]  phase_inc,
	input  wave_sel_e                wave_sel,
	output logic [`SYN_SAMPLE_W-1:0] sample,
	output logic                     sample_valid
);

	localparam int P = `SYN_PHASE_W;
	localparam int S = `SYN_SAMPLE_W;

	// first quadrant, sin((2i+1) * pi / 256) * 32767
	localparam logic [15:0] QTR_SINE [`SYN_SINE_DEPTH] = '{
		16'd402,   16'd1206,  16'd2009,  16'd2811,  16'd3612,  16'd4410,  16'd5205,  16'd5998,
		16'd6786,  16'd7571,  16'd8351,  16'd9126,  16'd9896,  16'd10659, 16'd11417, 16'd12167,
		16'd12910, 16'd13645, 16'd14372, 16'd15090, 16'd15800, 16'd16499, 16'd17189, 16'd17869,
		16'd18537, 16'd19195, 16'd19841, 16'd20475, 16'd21096, 16'd21705, 16'd22301, 16'd22884,
		16'd23452, 16'd24007, 16'd24547, 16'd25072, 16'd25582, 16'd26077, 16'd26556, 16'd27019,
		16'd27466, 16'd27896, 16'd28310, 16'd28706, 16'd29085, 16'd29447, 16'd29791, 16'd30117,
		16'd30424, 16'd30714, 16'd30985, 16'd31237, 16'd31470, 16'd31685, 16'd31880, 16'd32057,
		16'd32213, 16'd32351, 16'd32469, 16'd32567, 16'd32646, 16'd32705, 16'd32745, 16'd32765
	};

	logic [P-1:0]   phase;
	logic           tick_d;
	logic [5:0]     sine_idx;
	logic [15:0]    sine_mag;
	logic [S-2:0]   tri_fold;
	logic [S-1:0]   shaped;
	logic [S-1:0]   sample_reg;

	always_comb begin
		// second and fourth quadrants run the table backwards
		sine_idx = phase[P-2] ? ~phase[P-3:P-8] : phase[P-3:P-8];
		sine_mag = QTR_SINE[sine_idx];
		// fold the lower 15 bits so the ramp comes back down
		tri_fold = phase[P-1] ? ~phase[P-2:P-S] : phase[P-2:P-S];
		case (wave_sel)
			SQUARE:   shaped = {phase[P-1], {(S-1){~phase[P-1]}}};
			SAW:      shaped = {~phase[P-1], phase[P-2:P-S]};
			SINE:     shaped = phase[P-1] ? -sine_mag : sine_mag;
			TRIANGLE: shaped = {~tri_fold[S-2], tri_fold[S-3:0], 1'b0};
			default:  shaped = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			phase <= '0;
			tick_d <= 1'b0;
			sample_reg <= '0;
			sample_valid <= 1'b0;
		end else begin
			// silent voice parks the phase at zero
			if (phase_clear || !voice_on) begin
				phase <= '0;
			end else if (sample_tick) begin
				phase <= phase + phase_inc;
			end
			tick_d <= sample_tick;
			sample_valid <= tick_d;
			// shape the phase one cycle after it moved
			if (!voice_on) begin
				sample_reg <= '0;
			end else if (tick_d) begin
				sample_reg <= shaped;
			end
		end
	end

	// covers the cycle between gate drop and the register clearing
	assign sample = voice_on ? sample_reg : '0;

endmodule

`default_nettype wire
